// ==== logic/uart_cmd_pkg.sv ====
package uart_cmd_pkg;

    // system clock and serial line
    localparam int unsigned clk_hz     = 100_000_000;
    localparam int unsigned baud_rate  = 9600;
    localparam int unsigned oversample = 16;

    // 651 clocks per oversampling tick at 100 MHz
    localparam int unsigned baud_div   = clk_hz / (baud_rate * oversample);
    localparam int unsigned baud_cnt_w = $clog2(baud_div);

    localparam int unsigned tick_cnt_w     = $clog2(oversample);
    localparam int unsigned half_bit_ticks = oversample / 2;
    localparam int unsigned data_bits      = 8;
    localparam int unsigned bit_cnt_w      = $clog2(data_bits);

    // terminal counts at counter width
    localparam logic [baud_cnt_w-1:0] baud_last = baud_cnt_w'(baud_div - 1);
    localparam logic [tick_cnt_w-1:0] tick_last = tick_cnt_w'(oversample - 1);
    localparam logic [tick_cnt_w-1:0] half_last = tick_cnt_w'(half_bit_ticks - 1);
    localparam logic [bit_cnt_w-1:0]  bit_last  = bit_cnt_w'(data_bits - 1);

    // frame states shared by receiver and transmitter
    localparam logic [1:0] st_idle  = 2'd0;
    localparam logic [1:0] st_start = 2'd1;
    localparam logic [1:0] st_data  = 2'd2;
    localparam logic [1:0] st_stop  = 2'd3;

    // command letters
    localparam logic [data_bits-1:0] ascii_right = 8'h72;
    localparam logic [data_bits-1:0] ascii_left  = 8'h6c;
    localparam logic [data_bits-1:0] ascii_up    = 8'h75;
    localparam logic [data_bits-1:0] ascii_down  = 8'h64;
    localparam logic [data_bits-1:0] ascii_state = 8'h73;

    typedef struct packed {
        logic                 valid;
        logic [data_bits-1:0] data;
    } rx_byte_t;

    typedef struct packed {
        logic right;
        logic left;
        logic up;
        logic down;
    } btn_t;

endpackage

// ==== logic/baud_tick_gen.sv ====
`timescale 1ns/1ns

module baud_tick_gen (
    input  logic clk,
    input  logic rst,
    output logic o_tick
);

    logic [uart_cmd_pkg::baud_cnt_w-1:0] cnt;

    // one pulse every baud_div clocks
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cnt    <= '0;
            o_tick <= 1'b0;
        end else begin
            if (cnt == uart_cmd_pkg::baud_last) begin
                cnt    <= '0;
                o_tick <= 1'b1;
            end else begin
                cnt    <= cnt + 1'b1;
                o_tick <= 1'b0;
            end
        end
    end

endmodule

// ==== logic/uart_receiver.sv ====
`timescale 1ns/1ns

module uart_receiver (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   i_tick,
    input  logic                   i_rxd,
    output uart_cmd_pkg::rx_byte_t o_rx
);

    logic [1:0]                          state;
    logic [1:0]                          state_next;
    logic [uart_cmd_pkg::tick_cnt_w-1:0] tick_cnt;
    logic [uart_cmd_pkg::tick_cnt_w-1:0] tick_cnt_next;
    logic [uart_cmd_pkg::bit_cnt_w-1:0]  bit_cnt;
    logic [uart_cmd_pkg::bit_cnt_w-1:0]  bit_cnt_next;
    logic                                valid;
    logic                                valid_next;
    logic                                shift_en;
    logic [uart_cmd_pkg::data_bits-1:0]  shreg;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= uart_cmd_pkg::st_idle;
            tick_cnt <= '0;
            bit_cnt  <= '0;
            valid    <= 1'b0;
        end else begin
            state    <= state_next;
            tick_cnt <= tick_cnt_next;
            bit_cnt  <= bit_cnt_next;
            valid    <= valid_next;
        end
    end

    // lsb arrives first, so fill from the top
    always_ff @(posedge clk) begin
        if (shift_en) begin
            shreg <= {i_rxd, shreg[uart_cmd_pkg::data_bits-1:1]};
        end
    end

    always_comb begin
        state_next    = state;
        tick_cnt_next = tick_cnt;
        bit_cnt_next  = bit_cnt;
        valid_next    = 1'b0;
        shift_en      = 1'b0;

        case (state)
            uart_cmd_pkg::st_idle: begin
                tick_cnt_next = '0;
                bit_cnt_next  = '0;
                if (i_tick && !i_rxd) begin
                    state_next = uart_cmd_pkg::st_start;
                end
            end
            uart_cmd_pkg::st_start: begin
                // walk to the middle of the start bit
                if (i_tick) begin
                    if (tick_cnt == uart_cmd_pkg::half_last) begin
                        tick_cnt_next = '0;
                        state_next    = uart_cmd_pkg::st_data;
                    end else begin
                        tick_cnt_next = tick_cnt + 1'b1;
                    end
                end
            end
            uart_cmd_pkg::st_data: begin
                if (i_tick) begin
                    if (tick_cnt == uart_cmd_pkg::tick_last) begin
                        tick_cnt_next = '0;
                        shift_en      = 1'b1;
                        if (bit_cnt == uart_cmd_pkg::bit_last) begin
                            state_next = uart_cmd_pkg::st_stop;
                        end else begin
                            bit_cnt_next = bit_cnt + 1'b1;
                        end
                    end else begin
                        tick_cnt_next = tick_cnt + 1'b1;
                    end
                end
            end
            default: begin
                // stop bit level is not checked
                if (i_tick) begin
                    if (tick_cnt == uart_cmd_pkg::tick_last) begin
                        tick_cnt_next = '0;
                        valid_next    = 1'b1;
                        state_next    = uart_cmd_pkg::st_idle;
                    end else begin
                        tick_cnt_next = tick_cnt + 1'b1;
                    end
                end
            end
        endcase
    end

    assign o_rx.valid = valid;
    assign o_rx.data  = shreg;

endmodule

// ==== logic/command_select.sv ====
`timescale 1ns/1ns

module command_select (
    input  logic                   clk,
    input  logic                   rst,
    input  uart_cmd_pkg::rx_byte_t i_rx,
    input  uart_cmd_pkg::btn_t     i_btn,
    output uart_cmd_pkg::btn_t     o_btn,
    output logic                   o_state_req
);

    uart_cmd_pkg::btn_t cmd_btn;
    uart_cmd_pkg::btn_t req;
    uart_cmd_pkg::btn_t pick;
    logic               cmd_state;

    // command letters only count on the valid strobe
    always_comb begin
        cmd_btn   = '0;
        cmd_state = 1'b0;
        if (i_rx.valid) begin
            case (i_rx.data)
                uart_cmd_pkg::ascii_right: cmd_btn.right = 1'b1;
                uart_cmd_pkg::ascii_left:  cmd_btn.left  = 1'b1;
                uart_cmd_pkg::ascii_up:    cmd_btn.up    = 1'b1;
                uart_cmd_pkg::ascii_down:  cmd_btn.down  = 1'b1;
                uart_cmd_pkg::ascii_state: cmd_state     = 1'b1;
                default:                   cmd_btn       = '0;
            endcase
        end
    end

    assign req = cmd_btn | i_btn;

    // right wins, then left, up, down
    always_comb begin
        pick = '0;
        if (req.right) begin
            pick.right = 1'b1;
        end else if (req.left) begin
            pick.left = 1'b1;
        end else if (req.up) begin
            pick.up = 1'b1;
        end else if (req.down) begin
            pick.down = 1'b1;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            o_btn       <= '0;
            o_state_req <= 1'b0;
        end else begin
            o_btn       <= pick;
            o_state_req <= cmd_state;
        end
    end

endmodule

// ==== logic/uart_transmitter.sv ====
`timescale 1ns/1ns

module uart_transmitter (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   i_tick,
    input  uart_cmd_pkg::rx_byte_t i_tx,
    output logic                   o_txd
);

    logic [1:0]                          state;
    logic [1:0]                          state_next;
    logic [uart_cmd_pkg::tick_cnt_w-1:0] tick_cnt;
    logic [uart_cmd_pkg::tick_cnt_w-1:0] tick_cnt_next;
    logic [uart_cmd_pkg::bit_cnt_w-1:0]  bit_cnt;
    logic [uart_cmd_pkg::bit_cnt_w-1:0]  bit_cnt_next;
    logic [uart_cmd_pkg::data_bits-1:0]  shreg;
    logic [uart_cmd_pkg::data_bits-1:0]  shreg_next;
    logic                                txd_next;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= uart_cmd_pkg::st_idle;
            tick_cnt <= '0;
            bit_cnt  <= '0;
            o_txd    <= 1'b1;
        end else begin
            state    <= state_next;
            tick_cnt <= tick_cnt_next;
            bit_cnt  <= bit_cnt_next;
            o_txd    <= txd_next;
        end
    end

    always_ff @(posedge clk) begin
        shreg <= shreg_next;
    end

    always_comb begin
        state_next    = state;
        tick_cnt_next = tick_cnt;
        bit_cnt_next  = bit_cnt;
        shreg_next    = shreg;

        case (state)
            uart_cmd_pkg::st_idle: begin
                tick_cnt_next = '0;
                bit_cnt_next  = '0;
                // bytes arriving while busy are dropped
                if (i_tx.valid) begin
                    shreg_next = i_tx.data;
                    state_next = uart_cmd_pkg::st_start;
                end
            end
            uart_cmd_pkg::st_start: begin
                if (i_tick) begin
                    if (tick_cnt == uart_cmd_pkg::tick_last) begin
                        tick_cnt_next = '0;
                        state_next    = uart_cmd_pkg::st_data;
                    end else begin
                        tick_cnt_next = tick_cnt + 1'b1;
                    end
                end
            end
            uart_cmd_pkg::st_data: begin
                if (i_tick) begin
                    if (tick_cnt == uart_cmd_pkg::tick_last) begin
                        tick_cnt_next = '0;
                        if (bit_cnt == uart_cmd_pkg::bit_last) begin
                            state_next = uart_cmd_pkg::st_stop;
                        end else begin
                            bit_cnt_next = bit_cnt + 1'b1;
                            shreg_next   = {1'b0, shreg[uart_cmd_pkg::data_bits-1:1]};
                        end
                    end else begin
                        tick_cnt_next = tick_cnt + 1'b1;
                    end
                end
            end
            default: begin
                if (i_tick) begin
                    if (tick_cnt == uart_cmd_pkg::tick_last) begin
                        tick_cnt_next = '0;
                        state_next    = uart_cmd_pkg::st_idle;
                    end else begin
                        tick_cnt_next = tick_cnt + 1'b1;
                    end
                end
            end
        endcase

        // line level follows the state being entered
        case (state_next)
            uart_cmd_pkg::st_start: txd_next = 1'b0;
            uart_cmd_pkg::st_data:  txd_next = shreg_next[0];
            default:                txd_next = 1'b1;
        endcase
    end

endmodule

// ==== logic/uart_cmd_top.sv ====
`timescale 1ns/1ns

module uart_cmd_top (
    input  logic               clk,
    input  logic               rst,
    input  logic               i_uart_rx,
    input  uart_cmd_pkg::btn_t i_btn,
    output logic               o_uart_tx,
    output uart_cmd_pkg::btn_t o_btn,
    output logic               o_state_req
);

    logic                   tick;
    uart_cmd_pkg::rx_byte_t rx_byte;

    // 16x oversampling tick for both directions
    baud_tick_gen u_baud_tick (
        .clk   (clk),
        .rst   (rst),
        .o_tick(tick)
    );

    uart_receiver u_rx (
        .clk   (clk),
        .rst   (rst),
        .i_tick(tick),
        .i_rxd (i_uart_rx),
        .o_rx  (rx_byte)
    );

    command_select u_cmd_sel (
        .clk        (clk),
        .rst        (rst),
        .i_rx       (rx_byte),
        .i_btn      (i_btn),
        .o_btn      (o_btn),
        .o_state_req(o_state_req)
    );

    // echo every received byte
    uart_transmitter u_tx (
        .clk   (clk),
        .rst   (rst),
        .i_tick(tick),
        .i_tx  (rx_byte),
        .o_txd (o_uart_tx)
    );

endmodule

// ==== dv/uart_cmd_assertions.sv ====
`timescale 1ns/1ns

module uart_cmd_assertions (
    input logic               clk,
    input logic               rst,
    input logic               i_uart_tx,
    input uart_cmd_pkg::btn_t i_btn,
    input logic               i_state_req
);

    // priority merge leaves at most one button active
    a_btn_onehot: assert property (
        @(posedge clk) disable iff (rst) $onehot0(i_btn)
    ) else $error("o_btn has more than one bit set");

    // state request is a single-cycle pulse
    a_state_pulse: assert property (
        @(posedge clk) disable iff (rst) i_state_req |=> !i_state_req
    ) else $error("o_state_req held for two cycles");

    // line rests high while reset is applied
    a_tx_idle_in_reset: assert property (
        @(negedge clk) rst |-> i_uart_tx
    ) else $error("o_uart_tx low during reset");

endmodule

bind uart_cmd_top uart_cmd_assertions u_assertions (
    .clk        (clk),
    .rst        (rst),
    .i_uart_tx  (o_uart_tx),
    .i_btn      (o_btn),
    .i_state_req(o_state_req)
);

// ==== dv/tb_uart_cmd.sv ====
`timescale 1ns/1ns

module tb_uart_cmd;

    localparam int bit_clks       = uart_cmd_pkg::baud_div * uart_cmd_pkg::oversample;
    localparam int n_frames       = 30;
    localparam int mon_idle_limit = 30 * bit_clks;
    localparam int drain_limit    = 20 * bit_clks;
    localparam longint watchdog_ns = 600_000_000;

    localparam logic [7:0] ch_right = "r";
    localparam logic [7:0] ch_left  = "l";
    localparam logic [7:0] ch_up    = "u";
    localparam logic [7:0] ch_down  = "d";
    localparam logic [7:0] ch_state = "s";

    logic               clk;
    logic               rst;
    logic               i_uart_rx;
    logic               o_uart_tx;
    logic               o_state_req;
    uart_cmd_pkg::btn_t i_btn;
    uart_cmd_pkg::btn_t o_btn;
    logic [31:0]        rng;
    logic [7:0]         sent_q[$];
    logic [7:0]         echo_q[$];
    int                 value_errs;
    int                 other_errs;

    uart_cmd_top dut0 (
        .clk        (clk),
        .rst        (rst),
        .i_uart_rx  (i_uart_rx),
        .i_btn      (i_btn),
        .o_uart_tx  (o_uart_tx),
        .o_btn      (o_btn),
        .o_state_req(o_state_req)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // button request carried by a command byte
    function automatic uart_cmd_pkg::btn_t cmd_of(input logic [7:0] b);
        uart_cmd_pkg::btn_t c;
        c = '0;
        case (b)
            ch_right: c.right = 1'b1;
            ch_left:  c.left  = 1'b1;
            ch_up:    c.up    = 1'b1;
            ch_down:  c.down  = 1'b1;
            default:  c       = '0;
        endcase
        return c;
    endfunction

    function automatic uart_cmd_pkg::btn_t highest(input uart_cmd_pkg::btn_t req);
        uart_cmd_pkg::btn_t p;
        p = '0;
        if (req.right) begin
            p.right = 1'b1;
        end else if (req.left) begin
            p.left = 1'b1;
        end else if (req.up) begin
            p.up = 1'b1;
        end else if (req.down) begin
            p.down = 1'b1;
        end
        return p;
    endfunction

    task automatic report_value(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        value_errs++;
        $display("Error at %0t ns: %s expected %0h, got %0h", $time, name, exp, got);
    endtask

    task automatic report_other(input string what);
        other_errs++;
        $display("%s at %0t ns", what, $time);
    endtask

    // one frame plus two idle bits while counting output pulses
    task automatic send_frame(input logic [7:0] b, input uart_cmd_pkg::btn_t held);
        logic [11:0]        line;
        uart_cmd_pkg::btn_t idle_pick;
        uart_cmd_pkg::btn_t cmd_pick;
        uart_cmd_pkg::btn_t dev_val;
        int                 dev_cnt;
        int                 sreq_cnt;
        int                 exp_sreq;
        line      = {2'b11, 1'b1, b, 1'b0};
        idle_pick = highest(held);
        cmd_pick  = highest(held | cmd_of(b));
        dev_val   = '0;
        dev_cnt   = 0;
        sreq_cnt  = 0;
        exp_sreq  = (b == ch_state) ? 1 : 0;
        @(negedge clk);
        i_btn = held;
        @(negedge clk);
        if (o_btn !== idle_pick) begin
            report_value("o_btn", 32'(o_btn), 32'(idle_pick));
        end
        sent_q.push_back(b);
        for (int i = 0; i < 12; i++) begin
            for (int c = 0; c < bit_clks; c++) begin
                if (c == 0) begin
                    i_uart_rx = line[0];
                    line      = line >> 1;
                end
                @(negedge clk);
                if (o_btn !== idle_pick) begin
                    dev_cnt++;
                    dev_val = o_btn;
                end
                if (o_state_req) begin
                    sreq_cnt++;
                end
            end
        end
        if (cmd_pick != idle_pick) begin
            if (dev_cnt != 1) begin
                report_value("o_btn pulse count", dev_cnt, 1);
            end else if (dev_val !== cmd_pick) begin
                report_value("o_btn", 32'(dev_val), 32'(cmd_pick));
            end
        end else if (dev_cnt != 0) begin
            report_value("o_btn pulse count", dev_cnt, 0);
        end
        if (sreq_cnt != exp_sreq) begin
            report_value("o_state_req pulse count", sreq_cnt, exp_sreq);
        end
    endtask

    // recovers echoed bytes at mid bit
    initial begin : echo_monitor
        int         idle;
        logic [7:0] data;
        idle = 0;
        data = '0;
        while (idle < mon_idle_limit) begin
            @(negedge clk);
            if (!rst && o_uart_tx == 1'b0) begin
                idle = 0;
                repeat (bit_clks / 2) @(negedge clk);
                if (o_uart_tx !== 1'b0) begin
                    report_other("echo start bit did not stay low until mid bit");
                end
                for (int i = 0; i < 8; i++) begin
                    repeat (bit_clks) @(negedge clk);
                    data = {o_uart_tx, data[7:1]};
                end
                repeat (bit_clks) @(negedge clk);
                if (o_uart_tx !== 1'b1) begin
                    report_value("o_uart_tx stop bit", 32'(o_uart_tx), 1);
                end
                echo_q.push_back(data);
            end else begin
                idle++;
            end
        end
    end

    initial begin : watchdog
        #(watchdog_ns);
        $display("simulation ran past its time limit");
        $display("TEST FAIL");
        $finish;
    end

    initial begin : main
        int                 waited;
        int                 idx;
        int                 n;
        logic [31:0]        r;
        logic [7:0]         b;
        uart_cmd_pkg::btn_t held;
        rst        = 1'b1;
        i_uart_rx  = 1'b1;
        i_btn      = '0;
        rng        = 32'd99659;
        value_errs = 0;
        other_errs = 0;
        repeat (16) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        if (o_uart_tx !== 1'b1) begin
            report_value("o_uart_tx", 32'(o_uart_tx), 1);
        end
        if (o_btn !== '0) begin
            report_value("o_btn", 32'(o_btn), 0);
        end
        if (o_state_req !== 1'b0) begin
            report_value("o_state_req", 32'(o_state_req), 0);
        end

        for (int f = 0; f < n_frames; f++) begin
            rng = xorshift(rng);
            r   = rng;
            b   = r[15:8];
            idx = int'(r[10:8]) % 5;
            // first frames send each letter once with the buttons idle
            if (f < 5) begin
                idx = f;
            end
            if (f < 5 || r[0]) begin
                case (idx)
                    0:       b = ch_right;
                    1:       b = ch_left;
                    2:       b = ch_up;
                    3:       b = ch_down;
                    default: b = ch_state;
                endcase
            end
            // buttons held on about a quarter of the later frames
            held = '0;
            if (f >= 5 && r[21:20] == 2'b00) begin
                held = r[27:24];
            end
            send_frame(b, held);
        end

        waited = 0;
        while (echo_q.size() < sent_q.size() && waited < drain_limit) begin
            @(negedge clk);
            waited++;
        end
        if (echo_q.size() != sent_q.size()) begin
            report_other($sformatf("echoed %0d bytes but sent %0d",
                                   echo_q.size(), sent_q.size()));
        end
        n = (echo_q.size() < sent_q.size()) ? echo_q.size() : sent_q.size();
        for (int i = 0; i < n; i++) begin
            if (echo_q[i] !== sent_q[i]) begin
                report_value("o_uart_tx byte", 32'(echo_q[i]), 32'(sent_q[i]));
            end
        end

        $display("frames %0d, value errors %0d, other errors %0d",
                 sent_q.size(), value_errs, other_errs);
        if (value_errs + other_errs == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// ==== src.f ====
logic/uart_cmd_pkg.sv
logic/baud_tick_gen.sv
logic/uart_receiver.sv
logic/command_select.sv
logic/uart_transmitter.sv
logic/uart_cmd_top.sv
dv/uart_cmd_assertions.sv
dv/tb_uart_cmd.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f src.f --top-module tb_uart_cmd \
    -Mdir obj_dir -o vtb_uart_cmd || exit 1
out=$(./obj_dir/vtb_uart_cmd)
echo "$out"
echo "$out" | grep -qx "TEST PASS" && exit 0 || exit 1
